/* palu_settings.svh */
//--------------------------------------------------------------------
// PALU widths
// Word, byte enable and multiplier step counter sizes
//--------------------------------------------------------------------
`ifndef PALU_SETTINGS_SVH
`define PALU_SETTINGS_SVH

// Operand and result word
`define PALU_WORD_W 32

// Writeback byte enables
`define PALU_BEN_W 4

// Multiplier step counter, up to 32 steps
`define PALU_STEP_W 5

`endif

/* palu_pkg.sv */
//--------------------------------------------------------------------
// PALU types
// Instruction class, pack width, subclass codes and immediate views
//--------------------------------------------------------------------
`include "palu_settings.svh"

package palu_pkg;

    // Instruction class
    typedef enum logic [2:0] {
        CLS_MOVE    = 3'd1,
        CLS_BITWISE = 3'd2,
        CLS_PARITH  = 3'd3,
        CLS_TWIDDLE = 3'd4
    } palu_class_e;

    // Pack width, lane width is 32 >> pw
    typedef enum logic [2:0] {
        PW_32 = 3'd0,
        PW_16 = 3'd1,
        PW_8  = 3'd2,
        PW_4  = 3'd3,
        PW_2  = 3'd4
    } palu_pw_e;

    // Move subclasses
    localparam logic [3:0] SC_CMOV     = 4'd0;
    localparam logic [3:0] SC_CMOVN    = 4'd1;
    localparam logic [3:0] SC_GPR2XCR  = 4'd2;
    // Bitwise subclasses
    localparam logic [3:0] SC_LMIX     = 4'd0;
    localparam logic [3:0] SC_HMIX     = 4'd1;
    localparam logic [3:0] SC_BOP      = 4'd2;
    localparam logic [3:0] SC_INS      = 4'd3;
    localparam logic [3:0] SC_EXT      = 4'd4;
    localparam logic [3:0] SC_LLI      = 4'd5;
    localparam logic [3:0] SC_LUI      = 4'd6;
    // Twiddle subclasses, C0..C3 kept consecutive
    localparam logic [3:0] SC_TWID_B   = 4'd0;
    localparam logic [3:0] SC_TWID_N0  = 4'd1;
    localparam logic [3:0] SC_TWID_N1  = 4'd2;
    localparam logic [3:0] SC_TWID_C0  = 4'd3;
    localparam logic [3:0] SC_TWID_C1  = 4'd4;
    localparam logic [3:0] SC_TWID_C2  = 4'd5;
    localparam logic [3:0] SC_TWID_C3  = 4'd6;
    // Packed arithmetic subclasses
    localparam logic [3:0] SC_ADD      = 4'd0;
    localparam logic [3:0] SC_SUB      = 4'd1;
    localparam logic [3:0] SC_MUL      = 4'd2;
    localparam logic [3:0] SC_SLL      = 4'd3;
    localparam logic [3:0] SC_SRL      = 4'd4;
    localparam logic [3:0] SC_ROT      = 4'd5;
    localparam logic [3:0] SC_SLLI     = 4'd6;
    localparam logic [3:0] SC_SRLI     = 4'd7;
    localparam logic [3:0] SC_ROTI     = 4'd8;

    // Twiddle view, one select per output lane
    typedef struct packed {
        logic [`PALU_WORD_W-9:0] rsvd;
        logic [1:0]              sel3;   // Output lane 3
        logic [1:0]              sel2;
        logic [1:0]              sel1;
        logic [1:0]              sel0;   // Output lane 0
    } palu_twid_t;

    // Field view for ext and ins
    typedef struct packed {
        logic [`PALU_WORD_W-9:0] rsvd;
        logic [3:0]              start;  // In bit pairs
        logic [3:0]              len;    // In bit pairs
    } palu_field_t;

    typedef union packed {
        palu_twid_t  twid;
        palu_field_t field;
    } palu_imm_u;

endpackage

/* palu_packed_adder.sv */
//--------------------------------------------------------------------
// Packed adder
// Lane-wise add or subtract with carries cut at lane boundaries
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module palu_packed_adder (
    input  logic [`PALU_WORD_W-1:0] a,
    input  logic [`PALU_WORD_W-1:0] b,
    input  palu_pkg::palu_pw_e      pw,
    input  logic                    sub,   // Subtract a - b
    output logic [`PALU_WORD_W-1:0] c
);

    logic [4:0]              lane_mask;    // Lane width minus one
    logic [`PALU_WORD_W-1:0] b_op;         // b or its inverse

    assign lane_mask = 5'h1f >> pw;
    assign b_op      = sub ? ~b : b;

    // Ripple chain, restarted at each lane LSB
    always_comb begin
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < `PALU_WORD_W; i++) begin
            if ((i[4:0] & lane_mask) == 5'd0) begin
                carry = sub;               // Two's complement +1 per lane
            end
            c[i]  = a[i] ^ b_op[i] ^ carry;
            carry = (a[i] & b_op[i]) | (carry & (a[i] ^ b_op[i]));
        end
    end

endmodule

/* palu_packed_shifter.sv */
//--------------------------------------------------------------------
// Packed shifter
// Lane-local shift left, shift right and rotate
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module palu_packed_shifter (
    input  logic [`PALU_WORD_W-1:0] a,
    input  logic [4:0]              shamt,
    input  palu_pkg::palu_pw_e      pw,
    input  logic                    left,    // Else shift right
    input  logic                    rotate,  // Refill from same lane
    output logic [`PALU_WORD_W-1:0] c
);

    logic [4:0] lane_mask;
    logic [4:0] amt;         // Shift amount modulo lane width

    assign lane_mask = 5'h1f >> pw;
    assign amt       = shamt & lane_mask;

    // Each result bit picks its source bit inside its own lane
    always_comb begin
        logic [4:0] base;
        logic [5:0] off;
        logic [5:0] src;
        logic       in_lane;
        for (int i = 0; i < `PALU_WORD_W; i++) begin
            base = i[4:0] & ~lane_mask;
            off  = {1'b0, i[4:0] & lane_mask};
            if (left) begin
                src     = off - {1'b0, amt};
                in_lane = off >= {1'b0, amt};
            end else begin
                src     = off + {1'b0, amt};
                in_lane = src <= {1'b0, lane_mask};
            end
            // Bits crossing the lane edge are zero unless rotating
            c[i] = (in_lane || rotate) ? a[base | (src[4:0] & lane_mask)] : 1'b0;
        end
    end

endmodule

/* palu_packed_mult.sv */
//--------------------------------------------------------------------
// Packed multiplier
// Shift-and-add, one lane bit per cycle, on the shared adder and shifter
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module palu_packed_mult (
    input  logic                    g_clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [`PALU_WORD_W-1:0] a,
    input  logic [`PALU_WORD_W-1:0] b,
    input  palu_pkg::palu_pw_e      pw,
    input  logic [`PALU_WORD_W-1:0] add_c,    // Shared adder sum
    input  logic [`PALU_WORD_W-1:0] shf_c,    // Shared shifter output
    output logic [`PALU_WORD_W-1:0] add_a,
    output logic [`PALU_WORD_W-1:0] add_b,
    output logic [`PALU_WORD_W-1:0] shf_a,
    output logic [4:0]              shf_amt,
    output logic                    done,
    output logic [`PALU_WORD_W-1:0] result
);

    logic [4:0]              lane_mask;
    logic                    busy;      // Past the first step
    logic                    run;       // A step happens this cycle
    logic [`PALU_STEP_W-1:0] step;      // Current lane bit of b
    logic [`PALU_WORD_W-1:0] acc;       // Partial products so far
    logic [`PALU_WORD_W-1:0] b_mask;    // Lanes whose bit of b is set

    assign lane_mask = 5'h1f >> pw;
    assign run       = start || busy;
    assign done      = run && (step == lane_mask);   // Final lane bit

    assign shf_a   = a;
    assign shf_amt = step;                  // a << step, lane-local
    assign add_a   = busy ? acc : '0;       // First step starts from zero
    assign add_b   = shf_c & b_mask;
    assign result  = add_c;                 // Valid with done

    always_comb begin
        logic [4:0] base;
        for (int i = 0; i < `PALU_WORD_W; i++) begin
            base      = i[4:0] & ~lane_mask;
            b_mask[i] = b[base | step];
        end
    end

    //----------------------------------------------------------------
    // Step control
    //----------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (reset || done) begin
            busy <= 1'b0;
            step <= '0;
        end else if (run) begin
            busy <= 1'b1;
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (run) begin
            acc <= add_c;
        end
    end

    a_done_busy: assert property (@(posedge g_clk) disable iff (reset) done |-> busy);

    // Requester must hold the mul operands until done
    a_op_stable: assert property (@(posedge g_clk) disable iff (reset)
        busy |-> $stable(a) && $stable(b) && $stable(pw));

endmodule

/* palu_arith_unit.sv */
//--------------------------------------------------------------------
// Packed arithmetic unit
// Add, sub, shifts and mul on one shared adder and shifter
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module palu_arith_unit (
    input  logic                    g_clk,
    input  logic                    reset,
    input  logic                    ivalid,
    input  palu_pkg::palu_class_e   iclass,
    input  logic [3:0]              subclass,
    input  palu_pkg::palu_pw_e      pw,
    input  logic [`PALU_WORD_W-1:0] rs1,
    input  logic [`PALU_WORD_W-1:0] rs2,
    input  logic [`PALU_WORD_W-1:0] imm,
    output logic [`PALU_WORD_W-1:0] ar_result,
    output logic                    ar_done
);

    logic                    is_parith, is_add, is_sub, is_mul;
    logic                    is_sll, is_srl, is_rot, is_slli, is_srli, is_roti;
    logic                    is_shift;
    logic [`PALU_WORD_W-1:0] add_a, add_b, add_c, shf_a, shf_c;
    logic [4:0]              shamt;
    logic [`PALU_WORD_W-1:0] mul_add_a, mul_add_b, mul_result;
    logic [4:0]              mul_shf_amt;
    logic                    mul_done;

    // Subclass decode
    assign is_parith = ivalid && (iclass == palu_pkg::CLS_PARITH);
    assign is_add    = is_parith && (subclass == palu_pkg::SC_ADD);
    assign is_sub    = is_parith && (subclass == palu_pkg::SC_SUB);
    assign is_mul    = is_parith && (subclass == palu_pkg::SC_MUL);
    assign is_sll    = is_parith && (subclass == palu_pkg::SC_SLL);
    assign is_srl    = is_parith && (subclass == palu_pkg::SC_SRL);
    assign is_rot    = is_parith && (subclass == palu_pkg::SC_ROT);
    assign is_slli   = is_parith && (subclass == palu_pkg::SC_SLLI);
    assign is_srli   = is_parith && (subclass == palu_pkg::SC_SRLI);
    assign is_roti   = is_parith && (subclass == palu_pkg::SC_ROTI);
    assign is_shift  = is_sll || is_srl || is_rot || is_slli || is_srli || is_roti;

    // Multiplier owns the shared units while a mul runs
    assign add_a = is_mul ? mul_add_a : rs1;
    assign add_b = is_mul ? mul_add_b : rs2;
    assign shf_a = rs1;                          // Mul shifts rs1 as well
    assign shamt = is_mul                        ? mul_shf_amt :
                   (is_slli || is_srli || is_roti) ? imm[4:0]  : rs2[4:0];

    palu_packed_adder i_adder (
        .a(add_a), .b(add_b), .pw(pw), .sub(is_sub), .c(add_c)
    );

    palu_packed_shifter i_shifter (
        .a(shf_a), .shamt(shamt), .pw(pw),
        .left(is_mul || is_sll || is_slli), .rotate(is_rot || is_roti), .c(shf_c)
    );

    palu_packed_mult i_mult (
        .g_clk(g_clk), .reset(reset), .start(is_mul), .a(rs1), .b(rs2), .pw(pw),
        .add_c(add_c), .shf_c(shf_c), .add_a(mul_add_a), .add_b(mul_add_b),
        .shf_a(), .shf_amt(mul_shf_amt), .done(mul_done), .result(mul_result)
    );

    assign ar_result = ({`PALU_WORD_W{is_add || is_sub}} & add_c)      |
                       ({`PALU_WORD_W{is_shift}}         & shf_c)      |
                       ({`PALU_WORD_W{is_mul}}           & mul_result);
    assign ar_done   = is_mul ? mul_done : 1'b1;   // Only mul takes cycles

    a_pw_legal: assert property (@(posedge g_clk) disable iff (reset)
        ivalid |-> pw inside {palu_pkg::PW_32, palu_pkg::PW_16, palu_pkg::PW_8,
                              palu_pkg::PW_4, palu_pkg::PW_2});

endmodule

/* palu_bitwise_unit.sv */
//--------------------------------------------------------------------
// Bitwise unit
// Conditional moves, bitwise ops and twiddles, plus the move write enable
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module palu_bitwise_unit (
    input  logic                    ivalid,
    input  palu_pkg::palu_class_e   iclass,
    input  logic [3:0]              subclass,
    input  logic [`PALU_WORD_W-1:0] gpr_rs1,
    input  logic [`PALU_WORD_W-1:0] rs1,
    input  logic [`PALU_WORD_W-1:0] rs2,
    input  logic [`PALU_WORD_W-1:0] rs3,
    input  palu_pkg::palu_imm_u     imm,
    output logic [`PALU_WORD_W-1:0] bw_result,
    output logic                    bw_wen        // Move write condition
);

    logic [`PALU_WORD_W-1:0]   imm_w;               // Raw immediate bits
    logic [7:0]                sels;                // Twiddle selects, lane 3 high
    logic [3:0]                c_off;               // Crumb byte from C0..C3
    logic                      cmov_cond;
    logic [4:0]                ei_start, ei_len;    // In bits
    logic [`PALU_WORD_W-1:0]   field_mask, bop_res, ext_res, ins_res;
    logic [4:0]                mix_amt;
    logic [2*`PALU_WORD_W-1:0] mix_dbl;
    logic [`PALU_WORD_W-1:0]   mix_res;

    // Permute four elements of ew bits in the low part of src
    function automatic logic [`PALU_WORD_W-1:0] twid4(
        input logic [`PALU_WORD_W-1:0] src, input int ew, input logic [7:0] sel);
        logic [`PALU_WORD_W-1:0] res;
        res = '0;
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 8; j++) begin
                if (j < ew) begin
                    res[k*ew + j] = src[sel[2*k +: 2]*ew + j];
                end
            end
        end
        return res;
    endfunction

    assign imm_w     = imm;
    assign sels      = {imm.twid.sel3, imm.twid.sel2, imm.twid.sel1, imm.twid.sel0};
    assign c_off     = subclass - palu_pkg::SC_TWID_C0;
    assign cmov_cond = (rs2 == '0);

    // bop looks up the imm truth table per bit pair
    always_comb begin
        for (int i = 0; i < `PALU_WORD_W; i++) begin
            bop_res[i] = imm_w[{rs1[i], rs2[i]}];
        end
    end

    // ext and ins, start and length counted in bit pairs
    assign ei_start   = {imm.field.start, 1'b0};
    assign ei_len     = {imm.field.len, 1'b0};
    assign field_mask = ~({`PALU_WORD_W{1'b1}} << ei_len);
    assign ext_res    = (rs1 >> ei_start) & field_mask;
    assign ins_res    = ((rs1 & field_mask) << ei_start) | (rs3 & ~(field_mask << ei_start));

    // Mix rotates rs1 right, hmix adds 16
    assign mix_amt = {subclass == palu_pkg::SC_HMIX, imm_w[3:0]};
    assign mix_dbl = {rs1, rs1} >> mix_amt;
    assign mix_res = (rs2 & mix_dbl[`PALU_WORD_W-1:0]) | (~rs2 & rs3);

    //----------------------------------------------------------------
    // Result select
    //----------------------------------------------------------------
    always_comb begin
        logic [`PALU_WORD_W-1:0] tw;
        tw        = '0;
        bw_result = '0;
        bw_wen    = 1'b1;                   // Non-move classes always write
        if (ivalid && iclass == palu_pkg::CLS_MOVE) begin
            case (subclass)
                palu_pkg::SC_CMOV:    bw_wen = cmov_cond;
                palu_pkg::SC_CMOVN:   bw_wen = !cmov_cond;
                palu_pkg::SC_GPR2XCR: bw_wen = 1'b1;
                default:              bw_wen = 1'b0;
            endcase
            bw_result = (subclass == palu_pkg::SC_GPR2XCR) ? gpr_rs1 : rs1;
        end else if (ivalid && iclass == palu_pkg::CLS_BITWISE) begin
            case (subclass)
                palu_pkg::SC_LMIX, palu_pkg::SC_HMIX: bw_result = mix_res;
                palu_pkg::SC_BOP: bw_result = bop_res;
                palu_pkg::SC_INS: bw_result = ins_res;
                palu_pkg::SC_EXT: bw_result = ext_res;
                palu_pkg::SC_LLI: bw_result = {rs3[31:16], imm_w[15:0]};
                palu_pkg::SC_LUI: bw_result = {imm_w[15:0], rs3[15:0]};
                default:          bw_result = '0;
            endcase
        end else if (ivalid && iclass == palu_pkg::CLS_TWIDDLE) begin
            bw_result = rs1;                // Bits outside the field kept
            case (subclass)
                palu_pkg::SC_TWID_B: bw_result = twid4(rs1, 8, sels);
                palu_pkg::SC_TWID_N0: begin
                    tw               = twid4({16'h0, rs1[15:0]}, 4, sels);
                    bw_result[15:0]  = tw[15:0];
                end
                palu_pkg::SC_TWID_N1: begin
                    tw               = twid4({16'h0, rs1[31:16]}, 4, sels);
                    bw_result[31:16] = tw[15:0];
                end
                palu_pkg::SC_TWID_C0, palu_pkg::SC_TWID_C1,
                palu_pkg::SC_TWID_C2, palu_pkg::SC_TWID_C3: begin
                    tw = twid4({24'h0, rs1[8*c_off[1:0] +: 8]}, 2, sels);
                    bw_result[8*c_off[1:0] +: 8] = tw[7:0];
                end
                default: bw_result = '0;
            endcase
        end
    end

endmodule

/* palu_writeback.sv */
//--------------------------------------------------------------------
// Writeback
// Result select by class, idone and byte enables
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module palu_writeback (
    input  logic                    ivalid,
    input  palu_pkg::palu_class_e   iclass,
    input  logic [`PALU_WORD_W-1:0] bw_result,
    input  logic                    bw_wen,
    input  logic [`PALU_WORD_W-1:0] ar_result,
    input  logic                    ar_done,
    output logic                    idone,
    output logic [`PALU_BEN_W-1:0]  ben,
    output logic [`PALU_WORD_W-1:0] wdata
);

    logic is_parith;

    assign is_parith = (iclass == palu_pkg::CLS_PARITH);
    assign idone     = ivalid && (is_parith ? ar_done : 1'b1);  // Only mul waits
    assign wdata     = is_parith ? ar_result : bw_result;
    assign ben       = {`PALU_BEN_W{idone && bw_wen}};

    // Both units zero their results without a valid instruction
    always_comb begin
        a_idle_zero: assert final (ivalid || wdata == '0);
    end

endmodule

/* palu_top.sv */
//--------------------------------------------------------------------
// PALU top
// Bitwise and arithmetic units feeding one writeback stage
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module palu_top (
    input  logic                    g_clk,
    input  logic                    reset,
    input  logic                    ivalid,
    input  logic [`PALU_WORD_W-1:0] gpr_rs1,
    input  logic [`PALU_WORD_W-1:0] rs1,
    input  logic [`PALU_WORD_W-1:0] rs2,
    input  logic [`PALU_WORD_W-1:0] rs3,
    input  logic [`PALU_WORD_W-1:0] imm,
    input  palu_pkg::palu_pw_e      pw,
    input  palu_pkg::palu_class_e   iclass,
    input  logic [3:0]              subclass,
    output logic                    idone,
    output logic [`PALU_BEN_W-1:0]  ben,
    output logic [`PALU_WORD_W-1:0] wdata
);

    logic [`PALU_WORD_W-1:0] bw_result;
    logic                    bw_wen;
    logic [`PALU_WORD_W-1:0] ar_result;
    logic                    ar_done;

    palu_bitwise_unit i_bitwise (
        .ivalid(ivalid), .iclass(iclass), .subclass(subclass), .gpr_rs1(gpr_rs1),
        .rs1(rs1), .rs2(rs2), .rs3(rs3), .imm(imm),
        .bw_result(bw_result), .bw_wen(bw_wen)
    );

    palu_arith_unit i_arith (
        .g_clk(g_clk), .reset(reset), .ivalid(ivalid), .iclass(iclass),
        .subclass(subclass), .pw(pw), .rs1(rs1), .rs2(rs2), .imm(imm),
        .ar_result(ar_result), .ar_done(ar_done)
    );

    palu_writeback i_writeback (
        .ivalid(ivalid), .iclass(iclass), .bw_result(bw_result), .bw_wen(bw_wen),
        .ar_result(ar_result), .ar_done(ar_done),
        .idone(idone), .ben(ben), .wdata(wdata)
    );

endmodule

/* tb_palu.sv */
//--------------------------------------------------------------------
// PALU testbench
// Random instructions of every class against a reference model
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "palu_settings.svh"

module tb_palu;

    logic                    g_clk;
    logic                    reset;
    logic                    ivalid;
    logic [`PALU_WORD_W-1:0] gpr_rs1, rs1, rs2, rs3, imm;
    palu_pkg::palu_pw_e      pw;
    palu_pkg::palu_class_e   iclass;
    logic [3:0]              subclass;
    logic                    idone;
    logic [`PALU_BEN_W-1:0]  ben;
    logic [`PALU_WORD_W-1:0] wdata;

    logic [31:0] lfsr_state = 32'he5fd_b145;
    int          errors     = 0;
    int          timeouts   = 0;
    int          n_done     = 0;     // Completed instructions
    logic        stop       = 1'b0;  // Set on a timeout

    // Subclasses exercised per class
    logic [3:0] move_sc [3] = '{palu_pkg::SC_CMOV, palu_pkg::SC_CMOVN, palu_pkg::SC_GPR2XCR};
    logic [3:0] bw_sc   [7] = '{palu_pkg::SC_BOP, palu_pkg::SC_EXT, palu_pkg::SC_INS,
                                palu_pkg::SC_LMIX, palu_pkg::SC_HMIX, palu_pkg::SC_LLI,
                                palu_pkg::SC_LUI};
    logic [3:0] tw_sc   [7] = '{palu_pkg::SC_TWID_B, palu_pkg::SC_TWID_N0, palu_pkg::SC_TWID_N1,
                                palu_pkg::SC_TWID_C0, palu_pkg::SC_TWID_C1, palu_pkg::SC_TWID_C2,
                                palu_pkg::SC_TWID_C3};
    logic [3:0] ar_sc   [9] = '{palu_pkg::SC_ADD, palu_pkg::SC_SUB, palu_pkg::SC_MUL,
                                palu_pkg::SC_SLL, palu_pkg::SC_SRL, palu_pkg::SC_ROT,
                                palu_pkg::SC_SLLI, palu_pkg::SC_SRLI, palu_pkg::SC_ROTI};

    palu_top dut_i (
        .g_clk(g_clk), .reset(reset), .ivalid(ivalid), .gpr_rs1(gpr_rs1),
        .rs1(rs1), .rs2(rs2), .rs3(rs3), .imm(imm), .pw(pw), .iclass(iclass),
        .subclass(subclass), .idone(idone), .ben(ben), .wdata(wdata)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;       // 40 ns period
    end

    //----------------------------------------------------------------
    // Random source, taps 32, 22, 2, 1
    //----------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // One step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    //----------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------
    function automatic logic [31:0] bitwise_ref(input logic [3:0] sc,
        input logic [31:0] a, b, c, input palu_pkg::palu_imm_u iu);
        logic [31:0] r, m, rot, iw;
        int          s, n;
        iw = iu;
        r  = '0;
        s  = 2 * iu.field.start;            // Pairs of bits to bits
        n  = 2 * iu.field.len;
        m  = (n == 0) ? '0 : ({32{1'b1}} >> (32 - n));
        case (sc)
            palu_pkg::SC_LMIX, palu_pkg::SC_HMIX: begin
                n   = iw[3:0] + ((sc == palu_pkg::SC_HMIX) ? 16 : 0);
                rot = (a >> n) | (a << (32 - n));   // Rotate right
                r   = (b & rot) | (~b & c);
            end
            palu_pkg::SC_BOP: begin
                for (int i = 0; i < 32; i++) begin
                    r[i] = iw[2 * a[i] + b[i]];     // Truth table lookup
                end
            end
            palu_pkg::SC_EXT: r = (a >> s) & m;
            palu_pkg::SC_INS: r = ((a & m) << s) | (c & ~(m << s));
            palu_pkg::SC_LLI: r = {c[31:16], iw[15:0]};
            palu_pkg::SC_LUI: r = {iw[15:0], c[15:0]};
            default:          r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] twiddle_ref(input logic [3:0] sc,
        input logic [31:0] a, input palu_pkg::palu_imm_u iu);
        logic [31:0] r;
        logic [1:0]  sel [4];
        int          ew, base;
        sel = '{iu.twid.sel0, iu.twid.sel1, iu.twid.sel2, iu.twid.sel3};
        r   = a;                             // Untouched outside the field
        ew  = 2;
        base = 8 * (sc - palu_pkg::SC_TWID_C0);
        if (sc == palu_pkg::SC_TWID_B) begin
            ew   = 8;
            base = 0;
        end else if (sc == palu_pkg::SC_TWID_N0 || sc == palu_pkg::SC_TWID_N1) begin
            ew   = 4;
            base = (sc == palu_pkg::SC_TWID_N1) ? 16 : 0;
        end
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < ew; j++) begin
                r[base + k * ew + j] = a[base + sel[k] * ew + j];
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] parith_ref(input logic [3:0] sc,
        input palu_pkg::palu_pw_e w, input logic [31:0] a, b, iw);
        logic [31:0] r;
        logic [63:0] lm, x, y, z;
        int          lw, n;
        lw = 32 >> w;
        lm = (64'd1 << lw) - 1;
        n  = (sc == palu_pkg::SC_SLLI || sc == palu_pkg::SC_SRLI || sc == palu_pkg::SC_ROTI)
             ? iw[4:0] : b[4:0];
        n  = n % lw;                          // Amount modulo lane width
        r  = '0;
        for (int l = 0; l < 32 / lw; l++) begin
            x = (a >> (l * lw)) & lm;
            y = (b >> (l * lw)) & lm;
            case (sc)
                palu_pkg::SC_ADD:                   z = x + y;
                palu_pkg::SC_SUB:                   z = x - y;
                palu_pkg::SC_MUL:                   z = x * y;   // Low lane bits kept
                palu_pkg::SC_SLL, palu_pkg::SC_SLLI: z = x << n;
                palu_pkg::SC_SRL, palu_pkg::SC_SRLI: z = x >> n;
                default:                            z = (x >> n) | (x << (lw - n));
            endcase
            r = r | ((z & lm) << (l * lw));
        end
        return r;
    endfunction

    // Expected {ben, wdata}
    function automatic logic [`PALU_BEN_W+`PALU_WORD_W-1:0] ref_result(
        input palu_pkg::palu_class_e cls, input logic [3:0] sc, input palu_pkg::palu_pw_e w,
        input logic [31:0] g, a, b, c, iw);
        logic [31:0] r;
        logic [3:0]  be;
        be = 4'hf;
        case (cls)
            palu_pkg::CLS_MOVE: begin
                r = (sc == palu_pkg::SC_GPR2XCR) ? g : a;
                if ((sc == palu_pkg::SC_CMOV && b != '0) || (sc == palu_pkg::SC_CMOVN && b == '0))
                    be = 4'h0;                // Condition false, no write
            end
            palu_pkg::CLS_BITWISE: r = bitwise_ref(sc, a, b, c, iw);
            palu_pkg::CLS_TWIDDLE: r = twiddle_ref(sc, a, iw);
            default:               r = parith_ref(sc, w, a, b, iw);
        endcase
        return {be, r};
    endfunction

    // Cycles from first presentation to idone
    function automatic int latency(input palu_pkg::palu_class_e cls, input logic [3:0] sc,
        input palu_pkg::palu_pw_e w);
        return (cls == palu_pkg::CLS_PARITH && sc == palu_pkg::SC_MUL) ? (32 >> w) : 1;
    endfunction

    function automatic string instr_str();
        return $sformatf("cls=%0d sc=%0d pw=%0d rs1=%h rs2=%h rs3=%h imm=%h",
                         iclass, subclass, pw, rs1, rs2, rs3, imm);
    endfunction

    //----------------------------------------------------------------
    // Compare process, sampled on the rising edge
    //----------------------------------------------------------------
    initial begin : compare_proc
        int                                  wait_cycles;
        logic [`PALU_BEN_W+`PALU_WORD_W-1:0] exp_v;
        wait_cycles = 0;
        while (!stop) begin
            @(posedge g_clk);
            if (!ivalid) begin
                wait_cycles = 0;
                assert (idone == 1'b0 && ben == '0) else begin
                    errors++;
                    $display("[ERROR] %0t idle: idone=%b ben=%h", $time, idone, ben);
                end
            end else begin
                wait_cycles++;
                if (idone) begin
                    exp_v = ref_result(iclass, subclass, pw, gpr_rs1, rs1, rs2, rs3, imm);
                    assert (wdata == exp_v[`PALU_WORD_W-1:0]) else begin
                        errors++;
                        $display("[ERROR] %0t wdata %h exp %h: %s", $time, wdata,
                                 exp_v[`PALU_WORD_W-1:0], instr_str());
                    end
                    assert (ben == exp_v[`PALU_BEN_W+`PALU_WORD_W-1:`PALU_WORD_W]) else begin
                        errors++;
                        $display("[ERROR] %0t ben %h: %s", $time, ben, instr_str());
                    end
                    assert (wait_cycles == latency(iclass, subclass, pw)) else begin
                        errors++;
                        $display("[ERROR] %0t done after %0d cycles: %s", $time, wait_cycles,
                                 instr_str());
                    end
                    n_done++;
                    wait_cycles = 0;
                end else if (wait_cycles >= 40) begin
                    $display("Timeout: idone did not rise within 40 cycles at %0t", $time);
                    timeouts++;
                    stop = 1'b1;
                end
            end
        end
    end

    //----------------------------------------------------------------
    // Stimulus, driven on the falling edge
    //----------------------------------------------------------------
    task automatic issue(input palu_pkg::palu_class_e cls, input logic [3:0] sc,
                         input palu_pkg::palu_pw_e w);
        int target;
        int t;
        if (!stop) begin
            iclass   = cls;
            subclass = sc;
            pw       = w;
            gpr_rs1  = rand_bits(32);
            rs1      = rand_bits(32);
            rs2      = rand_bits(32);
            rs3      = rand_bits(32);
            imm      = rand_bits(32);
            if (cls == palu_pkg::CLS_MOVE && rand_bits(1) == 1)
                rs2 = '0;                     // Both cmov outcomes
            ivalid = 1'b1;
            target = n_done + 1;
            t      = 0;
            while (n_done < target && !stop && t < 50) begin
                @(negedge g_clk);
                t++;
            end
            if (n_done < target && !stop) begin
                $display("Timeout: instruction was never completed at %0t", $time);
                timeouts++;
                stop = 1'b1;
            end else if (rand_bits(2) == 0) begin
                ivalid = 1'b0;                // Occasional idle gap
                @(negedge g_clk);
            end
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d mismatches, %0d timeouts, %0d instructions",
                 errors, timeouts, n_done);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        reset    = 1'b1;
        ivalid   = 1'b0;
        gpr_rs1  = '0;
        rs1      = '0;
        rs2      = '0;
        rs3      = '0;
        imm      = '0;
        pw       = palu_pkg::PW_32;
        iclass   = palu_pkg::CLS_MOVE;
        subclass = '0;
        repeat (3) @(posedge g_clk);      // Three reset cycles
        @(negedge g_clk);
        reset = 1'b0;
        repeat (4) @(negedge g_clk);      // Idle after reset
        for (int n = 0; n < 10; n++) begin
            foreach (move_sc[k]) issue(palu_pkg::CLS_MOVE, move_sc[k], palu_pkg::PW_32);
            foreach (bw_sc[k]) issue(palu_pkg::CLS_BITWISE, bw_sc[k], palu_pkg::PW_32);
            foreach (tw_sc[k]) issue(palu_pkg::CLS_TWIDDLE, tw_sc[k], palu_pkg::PW_32);
        end
        // Every arithmetic form at every pack width, mul followed by others
        for (int n = 0; n < 4; n++) begin
            for (int p = 0; p < 5; p++) begin
                foreach (ar_sc[k]) issue(palu_pkg::CLS_PARITH, ar_sc[k], palu_pkg::palu_pw_e'(p));
            end
        end
        ivalid = 1'b0;
        repeat (2) @(negedge g_clk);
        finish_run();
    end

endmodule

/* tb.f */
+incdir+.
palu_pkg.sv
palu_packed_adder.sv
palu_packed_shifter.sv
palu_packed_mult.sv
palu_arith_unit.sv
palu_bitwise_unit.sv
palu_writeback.sv
palu_top.sv
tb_palu.sv
